// File: src/rv_isa_pkg.sv
// ISA types and encodings of the RV64I subset, imported by the pipeline package and every stage.
package rv_isa_pkg;

    localparam int unsigned xlen    = 64;
    localparam int unsigned shamt_w = $clog2(xlen);

    typedef logic [xlen-1:0] data_t;
    typedef logic [4:0]      reg_addr_t;
    typedef logic [31:0]     inst_t;
    typedef logic [63:0]     pc_t;

    // Field view of an R/I/U instruction word, MSB first.
    typedef struct packed {
        logic [6:0] funct7;
        reg_addr_t  rs2;
        reg_addr_t  rs1;
        logic [2:0] funct3;
        reg_addr_t  rd;
        logic [6:0] opcode;
    } inst_fields_t;

    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LUI    = 7'b0110111
    } opcode_e;

    typedef enum logic [2:0] {
        F3_ADD = 3'b000,
        F3_SLL = 3'b001,
        F3_SLT = 3'b010,
        F3_XOR = 3'b100,
        F3_SRL = 3'b101,
        F3_OR  = 3'b110,
        F3_AND = 3'b111
    } funct3_e;

    localparam logic [6:0] funct7_base = 7'b0000000;
    localparam logic [6:0] funct7_alt  = 7'b0100000; // Selects SUB over ADD.

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLL,
        ALU_SRL,
        ALU_SLT,
        ALU_PASS2
    } alu_op_e;

endpackage

// File: src/pipe_pkg.sv
// Bundles carried between pipeline stages and the stall controls, imported by the stage modules.
package pipe_pkg;

    import rv_isa_pkg::*;

    // Contents of the ID/EX register. An all-zero bundle is a bubble.
    typedef struct packed {
        logic      valid;
        pc_t       pc;
        inst_t     inst;
        alu_op_e   alu_op;
        data_t     op1;
        data_t     op2;
        logic      rd_ena;
        reg_addr_t rd_addr;
    } id_ex_t;

    // Contents of the EX/WB register, also the retirement report.
    typedef struct packed {
        logic      valid;
        pc_t       pc;
        logic      rd_ena;
        reg_addr_t rd_addr;
        data_t     result;
    } ex_wb_t;

    typedef struct packed {
        logic hold;        // Freeze both pipeline registers.
        logic bubble;      // Load a zero bundle into ID/EX.
        logic fetch_stall; // No instruction is accepted this cycle.
    } stall_ctrl_t;

endpackage

// File: src/reg_file.sv
// Integer register file with two read ports and a write-through write port fed by writeback.
`timescale 1ns/100ps

module reg_file import rv_isa_pkg::*, pipe_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  reg_addr_t rs1_addr,
    input  reg_addr_t rs2_addr,
    output data_t     rs1_data,
    output data_t     rs2_data,
    input  ex_wb_t    wb,
    input  logic      wr_en
);

    data_t regs [32];
    logic  wr_hit;

    // The new value is seen by a read in the same cycle as its write.
    function automatic data_t read_port(reg_addr_t addr);
        data_t value;
        if (addr == '0) begin
            value = '0;
        end else if (wr_hit && (addr == wb.rd_addr)) begin
            value = wb.result;
        end else begin
            value = regs[addr];
        end
        return value;
    endfunction

    assign wr_hit = wr_en && wb.rd_ena && (wb.rd_addr != '0); // x0 is never written.

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_hit) begin
            regs[wb.rd_addr] <= wb.result;
        end
    end

    always_comb begin
        rs1_data = read_port(rs1_addr);
        rs2_data = read_port(rs2_addr);
    end

endmodule

// File: src/decode_stage.sv
// Instruction decode that reads operands and builds the ID/EX bundle or flags the word as illegal.
`timescale 1ns/100ps

module decode_stage import rv_isa_pkg::*, pipe_pkg::*; (
    input  inst_t     inst,
    input  pc_t       pc,
    output reg_addr_t rs1_addr,
    output reg_addr_t rs2_addr,
    output logic      rs1_used,
    output logic      rs2_used,
    input  data_t     rs1_data,
    input  data_t     rs2_data,
    output id_ex_t    id_bundle,
    output logic      illegal
);

    inst_fields_t f;
    data_t        imm_i;
    data_t        imm_u;
    data_t        op2;
    alu_op_e      alu_op;
    logic         legal;

    assign f     = inst;
    assign imm_i = {{(xlen-12){inst[31]}}, inst[31:20]};
    assign imm_u = {{(xlen-32){inst[31]}}, inst[31:12], 12'b0};

    always_comb begin
        alu_op   = ALU_ADD;
        op2      = rs2_data;
        legal    = 1'b1;
        rs1_used = 1'b0;
        rs2_used = 1'b0;
        case (f.opcode)
            OPC_OP: begin
                rs1_used = 1'b1;
                rs2_used = 1'b1;
                if (f.funct7 == funct7_alt) begin
                    alu_op = ALU_SUB;
                    legal  = (f.funct3 == F3_ADD); // Only SUB uses the alternate funct7.
                end else if (f.funct7 == funct7_base) begin
                    case (f.funct3)
                        F3_ADD:  alu_op = ALU_ADD;
                        F3_SLL:  alu_op = ALU_SLL;
                        F3_SLT:  alu_op = ALU_SLT;
                        F3_XOR:  alu_op = ALU_XOR;
                        F3_SRL:  alu_op = ALU_SRL;
                        F3_OR:   alu_op = ALU_OR;
                        F3_AND:  alu_op = ALU_AND;
                        default: legal  = 1'b0;
                    endcase
                end else begin
                    legal = 1'b0;
                end
            end
            OPC_OP_IMM: begin
                rs1_used = 1'b1;
                op2      = imm_i;
                case (f.funct3)
                    F3_ADD:  alu_op = ALU_ADD;
                    F3_XOR:  alu_op = ALU_XOR;
                    F3_OR:   alu_op = ALU_OR;
                    F3_AND:  alu_op = ALU_AND;
                    default: legal  = 1'b0; // Shift and compare immediates are not supported.
                endcase
            end
            OPC_LUI: begin
                alu_op = ALU_PASS2;
                op2    = imm_u;
            end
            default: legal = 1'b0;
        endcase
        if (!legal) begin
            rs1_used = 1'b0; // An illegal word must not cause a RAW stall.
            rs2_used = 1'b0;
        end
    end

    always_comb begin
        id_bundle.valid   = legal;
        id_bundle.pc      = pc;
        id_bundle.inst    = inst;
        id_bundle.alu_op  = alu_op;
        id_bundle.op1     = rs1_data;
        id_bundle.op2     = op2;
        id_bundle.rd_ena  = legal;
        id_bundle.rd_addr = f.rd;
    end

    assign rs1_addr = f.rs1;
    assign rs2_addr = f.rs2;
    assign illegal  = ~legal;

endmodule

// File: src/id_ex_reg.sv
// ID/EX pipeline register that holds its bundle under hold and loads a zero bubble when told.
`timescale 1ns/100ps

module id_ex_reg import pipe_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        in_valid,
    input  id_ex_t      id_bundle,
    input  stall_ctrl_t stall,
    output id_ex_t      ex_bundle
);

    logic load_bubble;

    // No fetch strobe and an illegal word both become a bubble, just like a RAW stall.
    assign load_bubble = stall.bubble || !in_valid || !id_bundle.valid;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ex_bundle <= '0;
        end else if (!stall.hold) begin
            if (load_bubble) begin
                ex_bundle <= '0;
            end else begin
                ex_bundle <= id_bundle;
            end
        end
    end

endmodule

// File: src/exec_stage.sv
// Execute stage with the ALU and the EX/WB register whose output is the writeback bundle.
`timescale 1ns/100ps

module exec_stage import rv_isa_pkg::*, pipe_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  id_ex_t      ex_bundle,
    input  stall_ctrl_t stall,
    output ex_wb_t      wb,
    output logic        wr_en
);

    data_t             op1;
    data_t             op2;
    logic [shamt_w-1:0] shamt;
    data_t             alu_result;
    ex_wb_t            wb_q;

    assign op1   = ex_bundle.op1;
    assign op2   = ex_bundle.op2;
    assign shamt = op2[shamt_w-1:0]; // RV64 shifts use six bits.

    always_comb begin
        case (ex_bundle.alu_op)
            ALU_ADD:   alu_result = op1 + op2;
            ALU_SUB:   alu_result = op1 - op2;
            ALU_AND:   alu_result = op1 & op2;
            ALU_OR:    alu_result = op1 | op2;
            ALU_XOR:   alu_result = op1 ^ op2;
            ALU_SLL:   alu_result = op1 << shamt;
            ALU_SRL:   alu_result = op1 >> shamt;
            ALU_SLT:   alu_result = {{(xlen-1){1'b0}}, $signed(op1) < $signed(op2)};
            ALU_PASS2: alu_result = op2;
            default:   alu_result = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wb_q <= '0;
        end else if (!stall.hold) begin
            wb_q.valid   <= ex_bundle.valid;
            wb_q.pc      <= ex_bundle.pc;
            wb_q.rd_ena  <= ex_bundle.rd_ena;
            wb_q.rd_addr <= ex_bundle.rd_addr;
            wb_q.result  <= alu_result;
        end
    end

    // Retirement is reported in the one cycle that ends with the register file write.
    always_comb begin
        wb       = wb_q;
        wb.valid = wb_q.valid && !stall.hold;
    end

    assign wr_en = wb.valid;

endmodule

// File: src/hazard_ctrl.sv
// Hazard control that turns RAW matches against ID/EX and the external hold into stall controls.
`timescale 1ns/100ps

module hazard_ctrl import rv_isa_pkg::*, pipe_pkg::*; (
    input  reg_addr_t   rs1_addr,
    input  reg_addr_t   rs2_addr,
    input  logic        rs1_used,
    input  logic        rs2_used,
    input  logic        ex_rd_ena,
    input  reg_addr_t   ex_rd_addr,
    input  logic        inst_valid,
    input  logic        hold,
    output stall_ctrl_t stall
);

    logic rs1_hit;
    logic rs2_hit;
    logic raw;

    // A source read matches the pending destination in execute.
    function automatic logic src_hit(reg_addr_t addr, logic used);
        return used && ex_rd_ena && (ex_rd_addr != '0) && (addr == ex_rd_addr);
    endfunction

    assign rs1_hit = src_hit(rs1_addr, rs1_used);
    assign rs2_hit = src_hit(rs2_addr, rs2_used);

    // EX/WB matches are covered by register file write-through.
    assign raw = inst_valid && (rs1_hit || rs2_hit);

    always_comb begin
        stall.hold        = hold;
        stall.bubble      = raw;
        stall.fetch_stall = hold || raw;
    end

endmodule

// File: src/exec_core.sv
// Top level of the decode to writeback slice, driven by an external fetch and reporting retirements.
`timescale 1ns/100ps

module exec_core import rv_isa_pkg::*, pipe_pkg::*; (
    input  logic   clk,
    input  logic   rst_n,
    input  logic   inst_valid,
    input  inst_t  inst,
    input  pc_t    pc,
    input  logic   hold,
    output logic   fetch_stall,
    output logic   illegal_inst,
    output ex_wb_t wb
);

    reg_addr_t   rs1_addr;
    reg_addr_t   rs2_addr;
    logic        rs1_used;
    logic        rs2_used;
    data_t       rs1_data;
    data_t       rs2_data;
    id_ex_t      id_bundle;
    id_ex_t      ex_bundle;
    logic        dec_illegal;
    logic        wr_en;
    stall_ctrl_t stall;

    reg_file u_reg_file (
        .clk      (clk),
        .rst_n    (rst_n),
        .rs1_addr (rs1_addr),
        .rs2_addr (rs2_addr),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .wb       (wb),
        .wr_en    (wr_en)
    );

    decode_stage u_decode (
        .inst      (inst),
        .pc        (pc),
        .rs1_addr  (rs1_addr),
        .rs2_addr  (rs2_addr),
        .rs1_used  (rs1_used),
        .rs2_used  (rs2_used),
        .rs1_data  (rs1_data),
        .rs2_data  (rs2_data),
        .id_bundle (id_bundle),
        .illegal   (dec_illegal)
    );

    id_ex_reg u_id_ex (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (inst_valid),
        .id_bundle (id_bundle),
        .stall     (stall),
        .ex_bundle (ex_bundle)
    );

    exec_stage u_exec (
        .clk       (clk),
        .rst_n     (rst_n),
        .ex_bundle (ex_bundle),
        .stall     (stall),
        .wb        (wb),
        .wr_en     (wr_en)
    );

    hazard_ctrl u_hazard (
        .rs1_addr   (rs1_addr),
        .rs2_addr   (rs2_addr),
        .rs1_used   (rs1_used),
        .rs2_used   (rs2_used),
        .ex_rd_ena  (ex_bundle.rd_ena),
        .ex_rd_addr (ex_bundle.rd_addr),
        .inst_valid (inst_valid),
        .hold       (hold),
        .stall      (stall)
    );

    assign fetch_stall  = stall.fetch_stall;
    assign illegal_inst = dec_illegal && inst_valid && !stall.fetch_stall; // Only on acceptance.

endmodule

// File: testbench/tb_clock_gen.sv
// Clock and reset source for the core testbench, a 4 ns clock with reset held for three edges.
`timescale 1ns/100ps

module tb_clock_gen (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin
        rst_n = 1'b0;
        repeat (3) @(posedge clk);
        rst_n <= 1'b1; // Released after the third rising edge.
    end

endmodule

// File: testbench/exec_core_props.sv
// Concurrent checks on the pipeline controls, bound into the core by the testbench.
`timescale 1ns/100ps

module exec_core_props import pipe_pkg::*; (
    input logic   clk,
    input logic   rst_n,
    input logic   hold,
    input logic   fetch_stall,
    input logic   illegal_inst,
    input ex_wb_t wb
);

    hold_stalls_fetch: assert property (@(posedge clk) disable iff (!rst_n) hold |-> fetch_stall)
        else $error("fetch_stall is low while hold is high");

    hold_masks_retire: assert property (@(posedge clk) disable iff (!rst_n) hold |-> !wb.valid)
        else $error("wb.valid is high while hold is high");

    illegal_single_cycle: assert property (
        @(posedge clk) disable iff (!rst_n) illegal_inst |=> !illegal_inst)
        else $error("illegal_inst stayed high for more than one cycle");

    // Both pipeline registers come out of reset empty.
    reset_quiet: assert property (@(posedge clk) $rose(rst_n) |-> !wb.valid && !fetch_stall)
        else $error("wb.valid or fetch_stall is high right after reset");

endmodule

// File: testbench/exec_core_tb.sv
// Table-driven testbench for the decode to writeback core, run from tb.f through the Makefile.
`timescale 1ns/100ps

module exec_core_tb import rv_isa_pkg::*, pipe_pkg::*; ();

    // One table row is a fetched instruction together with its expected retirement.
    typedef struct packed {
        inst_t      inst;
        pc_t        pc;
        logic [3:0] hold_cycles; // Cycles of hold raised while the word is presented.
        logic       stall_exp;
        logic       legal;
        reg_addr_t  rd;
        data_t      result;
    } stim_t;

    logic   clk;
    logic   rst_n;
    logic   inst_valid;
    inst_t  inst;
    pc_t    pc;
    logic   hold;
    logic   fetch_stall;
    logic   illegal_inst;
    ex_wb_t wb;

    stim_t table_q [$];
    stim_t exp_q [$];
    data_t model_regs [32];
    int    seed = 32'h4ccba933;

    tb_clock_gen u_clock_gen (.clk(clk), .rst_n(rst_n));

    exec_core u_exec_core (.*);

    bind exec_core exec_core_props u_props (.*);

    task automatic abort_run();
        $display("TEST FAILED");
        $fatal(1, "Simulation stopped at the first error.");
    endtask

    task automatic check_data(input string name, input data_t got, input data_t exp);
        if (got !== exp) begin
            $display("FAIL at %0t: %s is %h, expected %h", $time, name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_addr(input string name, input reg_addr_t got, input reg_addr_t exp);
        if (got !== exp) begin
            $display("FAIL at %0t: %s is %0d, expected %0d", $time, name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_pc(input string name, input pc_t got, input pc_t exp);
        if (got !== exp) begin
            $display("FAIL at %0t: %s is %h, expected %h", $time, name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("FAIL at %0t: %s is %b, expected %b", $time, name, got, exp);
            abort_run();
        end
    endtask

    function automatic inst_t enc_r(logic [6:0] f7, logic [2:0] f3, reg_addr_t rd,
                                    reg_addr_t rs1, reg_addr_t rs2);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic inst_t enc_i(logic [2:0] f3, reg_addr_t rd, reg_addr_t rs1,
                                    logic [11:0] imm);
        return {imm, rs1, f3, rd, 7'b0010011};
    endfunction

    function automatic data_t sext12(logic [11:0] imm);
        return {{52{imm[11]}}, imm};
    endfunction

    function automatic data_t slt(data_t a, data_t b);
        return ($signed(a) < $signed(b)) ? 64'd1 : 64'd0;
    endfunction

    task automatic add_entry(input inst_t word, input data_t res, input logic legal,
                             input logic stall_exp, input int hold_n);
        stim_t s;
        s.inst        = word;
        s.pc          = 64'h1000 + 64'(4 * table_q.size());
        s.hold_cycles = 4'(hold_n);
        s.stall_exp   = stall_exp;
        s.legal       = legal;
        s.rd          = word[11:7];
        s.result      = res;
        table_q.push_back(s);
        if (legal) begin
            exp_q.push_back(s);
        end
        if (legal && s.rd != 5'd0) begin
            model_regs[s.rd] = res; // x0 keeps reading zero.
        end
    endtask

    task automatic build_table();
        logic [63:0] rnd;
        logic [19:0] imm_u;
        logic [11:0] imm_n;
        logic [11:0] imm_a;
        logic [11:0] imm_b;
        logic [11:0] imm_c;
        rnd   = {$random(seed), $random(seed)};
        imm_u = {1'b1, rnd[18:0]}; // Negative upper immediate.
        imm_n = {1'b1, rnd[29:19]};
        imm_a = rnd[41:30];
        imm_b = {1'b1, rnd[52:42]};
        imm_c = {1'b0, rnd[63:53]};
        foreach (model_regs[i]) model_regs[i] = '0;
        add_entry({imm_u, 5'd1, 7'b0110111}, {{32{imm_u[19]}}, imm_u, 12'h000}, 1, 0, 0);
        add_entry(enc_i(3'b000, 5'd2, 5'd0, imm_n), sext12(imm_n), 1, 0, 0);
        add_entry(enc_i(3'b000, 5'd3, 5'd0, imm_a), sext12(imm_a), 1, 0, 0);
        add_entry(enc_r(7'h00, 3'b000, 5'd4, 5'd1, 5'd2), model_regs[1] + model_regs[2], 1, 0, 0);
        add_entry(enc_r(7'h20, 3'b000, 5'd5, 5'd4, 5'd3), model_regs[4] - model_regs[3], 1, 1, 0);
        add_entry(enc_r(7'h00, 3'b111, 5'd6, 5'd1, 5'd3), model_regs[1] & model_regs[3], 1, 0, 0);
        add_entry(enc_r(7'h00, 3'b110, 5'd7, 5'd2, 5'd3), model_regs[2] | model_regs[3], 1, 0, 3);
        add_entry(enc_r(7'h00, 3'b100, 5'd8, 5'd1, 5'd2), model_regs[1] ^ model_regs[2], 1, 0, 0);
        add_entry(enc_r(7'h00, 3'b001, 5'd9, 5'd1, 5'd3),
                  model_regs[1] << model_regs[3][5:0], 1, 0, 0);
        add_entry(enc_r(7'h00, 3'b101, 5'd10, 5'd1, 5'd3),
                  model_regs[1] >> model_regs[3][5:0], 1, 0, 0);
        add_entry(enc_r(7'h00, 3'b010, 5'd11, 5'd2, 5'd3),
                  slt(model_regs[2], model_regs[3]), 1, 0, 0);
        add_entry(enc_r(7'h00, 3'b010, 5'd12, 5'd3, 5'd2),
                  slt(model_regs[3], model_regs[2]), 1, 0, 0);
        add_entry(enc_r(7'h20, 3'b111, 5'd13, 5'd12, 5'd12), '0, 0, 0, 0); // No such encoding.
        add_entry(enc_i(3'b111, 5'd13, 5'd1, imm_b), model_regs[1] & sext12(imm_b), 1, 0, 0);
        add_entry(enc_i(3'b110, 5'd14, 5'd2, imm_c), model_regs[2] | sext12(imm_c), 1, 0, 2);
        add_entry(enc_i(3'b100, 5'd15, 5'd13, imm_n), model_regs[13] ^ sext12(imm_n), 1, 0, 0);
        add_entry(enc_i(3'b000, 5'd0, 5'd1, imm_a), model_regs[1] + sext12(imm_a), 1, 0, 0);
        add_entry(enc_r(7'h00, 3'b000, 5'd16, 5'd0, 5'd1), model_regs[0] + model_regs[1], 1, 0, 0);
        add_entry(enc_i(3'b000, 5'd17, 5'd16, imm_b), model_regs[16] + sext12(imm_b), 1, 1, 0);
    endtask

    // Called on a rising edge, returns on the edge that accepts the word.
    task automatic present(input stim_t s);
        int stalls;
        inst       <= s.inst;
        pc         <= s.pc;
        inst_valid <= 1'b1;
        if (s.hold_cycles != 0) begin
            hold <= 1'b1;
            for (int i = 0; i < s.hold_cycles; i++) begin
                @(posedge clk);
            end
            hold <= 1'b0;
        end
        stalls = 0;
        @(negedge clk);
        while (fetch_stall) begin
            stalls++;
            if (stalls > 16) begin
                $display("Timeout: fetch_stall never dropped for the word at pc %h", s.pc);
                abort_run();
            end
            @(negedge clk);
        end
        check_flag("illegal_inst", illegal_inst, !s.legal);
        if ((stalls != 0) != s.stall_exp) begin
            $display("Word at pc %h saw %0d stall cycles against the RAW rule", s.pc, stalls);
            abort_run();
        end
        @(posedge clk);
    endtask

    // Retirements are taken in order at the falling edge.
    initial begin
        stim_t want;
        forever begin
            @(negedge clk);
            if (rst_n && wb.valid) begin
                if (exp_q.size() == 0) begin
                    $display("Retirement at pc %h was not expected", wb.pc);
                    abort_run();
                end
                want = exp_q.pop_front();
                check_pc("wb.pc", wb.pc, want.pc);
                check_flag("wb.rd_ena", wb.rd_ena, 1'b1);
                check_addr("wb.rd_addr", wb.rd_addr, want.rd);
                check_data("wb.result", wb.result, want.result);
            end
        end
    end

    initial begin
        int waited;
        inst_valid <= 1'b0;
        inst       <= '0;
        pc         <= '0;
        hold       <= 1'b0;
        build_table();
        waited = 0;
        while (rst_n !== 1'b1) begin
            waited++;
            if (waited > 10) begin
                $display("Timeout: reset was never released");
                abort_run();
            end
            @(posedge clk);
        end
        foreach (table_q[i]) begin
            present(table_q[i]);
        end
        inst_valid <= 1'b0;
        waited = 0;
        while (exp_q.size() != 0) begin
            waited++;
            if (waited > 32) begin
                $display("Timeout: %0d instructions never retired", exp_q.size());
                abort_run();
            end
            @(posedge clk);
        end
        repeat (4) @(posedge clk); // Room for a stray retirement to show up.
        $display("TEST PASSED");
        $finish;
    end

endmodule

// File: tb.f
src/rv_isa_pkg.sv
src/pipe_pkg.sv
src/reg_file.sv
src/decode_stage.sv
src/id_ex_reg.sv
src/exec_stage.sv
src/hazard_ctrl.sv
src/exec_core.sv
testbench/tb_clock_gen.sv
testbench/exec_core_props.sv
testbench/exec_core_tb.sv

// File: Makefile
TOP := exec_core_tb

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): tb.f $(wildcard src/*.sv testbench/*.sv)
	verilator --binary --timing --assert -f tb.f --top-module $(TOP) -o V$(TOP)

run: obj_dir/V$(TOP)
	obj_dir/V$(TOP) | tee sim.log
	grep -q "TEST PASSED" sim.log

lint:
	verilator --lint-only --timing --assert -f tb.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log
